/* logic/rv32i_pkg.sv */
//================================================
// RV32I instruction-set definitions
// Widths, field positions, opcodes and load widths
//================================================

`default_nettype none

package rv32i_pkg;

    //================================================
    // Widths
    //================================================
    localparam int XLEN       = 32;         // Data and address width
    localparam int REG_ADDR_W = 5;          // Register file index
    localparam int BYTE_OFS_W = 2;          // Byte lane within a word

    //================================================
    // Instruction field positions
    //================================================
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int IMM12_LSB  = 20;         // I-type immediate
    localparam int IMM12_MSB  = 31;
    localparam int UIMM_LSB   = 12;         // Bottom of U-type immediate

    // Major opcodes of the base integer set
    typedef enum logic [OPCODE_MSB-OPCODE_LSB:0] {
        OP     = 7'b0110011,                // Register-register ALU
        OP_IMM = 7'b0010011,                // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011                 // ECALL and EBREAK
    } opcode_e;

    // funct3 of LOAD
    typedef enum logic [FUNCT3_MSB-FUNCT3_LSB:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_f3_e;

    localparam logic [XLEN-1:0] NOP_INST     = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [11:0]     EBREAK_IMM12 = 12'h001;        // SYSTEM imm12 of EBREAK

endpackage

`default_nettype wire

/* logic/wb_pkg.sv */
//================================================
// Write-back stage definitions
// Result sources and stage constants
//================================================

`default_nettype none

package wb_pkg;

    localparam int SRC_W = 3;               // Result source select width

    // Origin of the register write value
    typedef enum logic [SRC_W-1:0] {
        SRC_ALU   = 3'd0,                   // ALU result from execute
        SRC_LOAD  = 3'd1,                   // Aligned load data
        SRC_LINK  = 3'd2,                   // Return address of JAL/JALR
        SRC_UIMM  = 3'd3,                   // LUI immediate
        SRC_AUIPC = 3'd4                    // PC plus U immediate
    } wb_src_e;

    // Return address increment
    localparam logic [rv32i_pkg::XLEN-1:0] PC_STEP = 32'd4;

endpackage

`default_nettype wire

/* logic/mem_wb_reg.sv */
//================================================
// MEM/WB pipeline register
// Holds one instruction, resets to a NOP bubble
//================================================

`default_nettype none
`timescale 1ns/10ps

module mem_wb_reg (
    input  logic                               i_clk,
    input  logic                               i_rst,             // Sync, active high
    input  logic                               i_valid,           // Instruction strobe
    input  logic [rv32i_pkg::XLEN-1:0]         i_inst,
    input  logic [rv32i_pkg::XLEN-1:0]         i_pc,
    input  logic [rv32i_pkg::XLEN-1:0]         i_next_pc,
    input  logic [rv32i_pkg::XLEN-1:0]         i_alu_result,
    input  logic [rv32i_pkg::BYTE_OFS_W-1:0]   i_byte_offset,     // Low address bits
    input  logic                               i_unaligned_pc,
    input  logic                               i_unaligned_mem,
    output logic                               o_valid,
    output logic [rv32i_pkg::XLEN-1:0]         o_inst,
    output logic [rv32i_pkg::XLEN-1:0]         o_pc,
    output logic [rv32i_pkg::XLEN-1:0]         o_next_pc,
    output logic [rv32i_pkg::XLEN-1:0]         o_alu_result,
    output logic [rv32i_pkg::BYTE_OFS_W-1:0]   o_byte_offset,
    output logic                               o_unaligned_pc,
    output logic                               o_unaligned_mem
);

    import rv32i_pkg::*;

    //================================================
    // Capture on every edge, no stall
    //================================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid         <= 1'b0;        // Bubble
            o_inst          <= NOP_INST;    // Retire port shows a NOP
            o_pc            <= '0;
            o_next_pc       <= '0;
            o_alu_result    <= '0;
            o_byte_offset   <= '0;
            o_unaligned_pc  <= 1'b0;
            o_unaligned_mem <= 1'b0;
        end else begin
            o_valid         <= i_valid;
            o_inst          <= i_inst;
            o_pc            <= i_pc;
            o_next_pc       <= i_next_pc;
            o_alu_result    <= i_alu_result;
            o_byte_offset   <= i_byte_offset;
            o_unaligned_pc  <= i_unaligned_pc;
            o_unaligned_mem <= i_unaligned_mem;
        end
    end

endmodule

`default_nettype wire

/* logic/wb_ctrl.sv */
//================================================
// Write-back control decode
// Result source, rd write, trap and halt
//================================================

`default_nettype none
`timescale 1ns/10ps

module wb_ctrl (
    input  logic                        i_valid,          // Registered strobe
    input  logic [rv32i_pkg::XLEN-1:0]  i_inst,           // Registered instruction
    input  logic                        i_unaligned_pc,
    input  logic                        i_unaligned_mem,
    output wb_pkg::wb_src_e             o_src,            // Write value select
    output logic                        o_writes_rd,      // Register file write
    output logic                        o_trap,
    output logic                        o_halt
);

    import rv32i_pkg::*;
    import wb_pkg::*;

    opcode_e                           opcode;
    logic [FUNCT3_MSB-FUNCT3_LSB:0]    funct3;
    logic [IMM12_MSB-IMM12_LSB:0]      imm12;
    logic                              dec_writes;        // Opcode has an rd
    logic                              dec_legal;         // Opcode is in RV32I
    logic                              is_ebreak;

    // Instruction fields
    assign opcode = opcode_e'(i_inst[OPCODE_MSB:OPCODE_LSB]);
    assign funct3 = i_inst[FUNCT3_MSB:FUNCT3_LSB];
    assign imm12  = i_inst[IMM12_MSB:IMM12_LSB];

    //================================================
    // Opcode decode
    //================================================
    always_comb begin
        o_src      = SRC_ALU;               // OP, OP_IMM and non-writers
        dec_writes = 1'b0;
        dec_legal  = 1'b1;
        case (opcode)
            OP, OP_IMM: begin
                dec_writes = 1'b1;
            end
            LOAD: begin
                o_src      = SRC_LOAD;
                dec_writes = 1'b1;
            end
            JAL, JALR: begin
                o_src      = SRC_LINK;      // Return address
                dec_writes = 1'b1;
            end
            LUI: begin
                o_src      = SRC_UIMM;
                dec_writes = 1'b1;
            end
            AUIPC: begin
                o_src      = SRC_AUIPC;
                dec_writes = 1'b1;
            end
            STORE, BRANCH, SYSTEM: begin
                dec_writes = 1'b0;          // No destination
            end
            default: begin
                dec_legal  = 1'b0;          // Undefined opcode
            end
        endcase
    end

    // EBREAK is SYSTEM, funct3 zero, imm12 one
    assign is_ebreak = (opcode == SYSTEM) && (funct3 == '0) && (imm12 == EBREAK_IMM12);

    assign o_writes_rd = i_valid && dec_writes;
    assign o_trap      = i_valid && (!dec_legal || i_unaligned_pc || i_unaligned_mem);
    assign o_halt      = o_trap || (i_valid && is_ebreak);  // Any trap stops the core

endmodule

`default_nettype wire

/* logic/load_align.sv */
//================================================
// Load data alignment
// Picks and extends the loaded byte or halfword
//================================================

`default_nettype none
`timescale 1ns/10ps

module load_align (
    input  logic [rv32i_pkg::FUNCT3_MSB-rv32i_pkg::FUNCT3_LSB:0] i_funct3,      // Load width
    input  logic [rv32i_pkg::BYTE_OFS_W-1:0]                   i_byte_offset,
    input  logic [rv32i_pkg::XLEN-1:0]                         i_rdata,       // Raw memory word
    output logic [rv32i_pkg::XLEN-1:0]                         o_load_data
);

    import rv32i_pkg::*;

    load_f3_e     width;
    logic [7:0]   lane_byte;                // Byte at the offset
    logic [15:0]  lane_half;                // Half chosen by offset[1]

    assign width     = load_f3_e'(i_funct3);
    assign lane_byte = i_rdata[8*i_byte_offset +: 8];
    assign lane_half = i_byte_offset[1] ? i_rdata[31:16] : i_rdata[15:0];

    //================================================
    // Extension by width
    //================================================
    always_comb begin
        case (width)
            LB:      o_load_data = {{(XLEN-8){lane_byte[7]}}, lane_byte};    // Sign extend
            LBU:     o_load_data = {{(XLEN-8){1'b0}}, lane_byte};            // Zero extend
            LH:      o_load_data = {{(XLEN-16){lane_half[15]}}, lane_half};
            LHU:     o_load_data = {{(XLEN-16){1'b0}}, lane_half};
            default: o_load_data = i_rdata;                                  // LW and others
        endcase
    end

endmodule

`default_nettype wire

/* logic/wb_select.sv */
//================================================
// Write-back result select
// Builds the register write value
//================================================

`default_nettype none
`timescale 1ns/10ps

module wb_select (
    input  wb_pkg::wb_src_e             i_src,
    input  logic [rv32i_pkg::XLEN-1:0]  i_alu_result,
    input  logic [rv32i_pkg::XLEN-1:0]  i_load_data,      // Aligned load value
    input  logic [rv32i_pkg::XLEN-1:0]  i_pc,
    input  logic [rv32i_pkg::XLEN-1:0]  i_inst,
    output logic [rv32i_pkg::XLEN-1:0]  o_rd_data
);

    import rv32i_pkg::*;
    import wb_pkg::*;

    logic [XLEN-1:0] uimm;                  // U-type immediate, low bits zero
    logic [XLEN-1:0] link_addr;             // pc + 4
    logic [XLEN-1:0] auipc_sum;

    assign uimm      = {i_inst[XLEN-1:UIMM_LSB], {UIMM_LSB{1'b0}}};
    assign link_addr = i_pc + PC_STEP;
    assign auipc_sum = i_pc + uimm;

    always_comb begin
        case (i_src)
            SRC_LOAD:  o_rd_data = i_load_data;
            SRC_LINK:  o_rd_data = link_addr;    // JAL, JALR
            SRC_UIMM:  o_rd_data = uimm;         // LUI
            SRC_AUIPC: o_rd_data = auipc_sum;
            default:   o_rd_data = i_alu_result; // SRC_ALU
        endcase
    end

endmodule

`default_nettype wire

/* logic/wb_stage.sv */
//================================================
// RV32I write-back stage
// Register file write and instruction retire
//================================================

`default_nettype none
`timescale 1ns/10ps

module wb_stage (
    input  logic                               i_clk,
    input  logic                               i_rst,             // Sync, active high
    // From memory stage
    input  logic                               i_valid,           // One instruction per strobe
    input  logic [rv32i_pkg::XLEN-1:0]         i_inst,
    input  logic [rv32i_pkg::XLEN-1:0]         i_pc,
    input  logic [rv32i_pkg::XLEN-1:0]         i_next_pc,
    input  logic [rv32i_pkg::XLEN-1:0]         i_alu_result,
    input  logic [rv32i_pkg::BYTE_OFS_W-1:0]   i_byte_offset,     // Load address low bits
    input  logic                               i_unaligned_pc,
    input  logic                               i_unaligned_mem,
    // Data memory, one cycle after the strobe
    input  logic [rv32i_pkg::XLEN-1:0]         i_dmem_rdata,
    // Register file write port
    output logic [rv32i_pkg::REG_ADDR_W-1:0]   o_wb_rd,
    output logic [rv32i_pkg::XLEN-1:0]         o_wb_rd_data,
    output logic                               o_wb_reg_write,
    // Retire port
    output logic                               o_retire_valid,
    output logic [rv32i_pkg::XLEN-1:0]         o_retire_inst,
    output logic                               o_retire_trap,
    output logic                               o_retire_halt,
    output logic [rv32i_pkg::REG_ADDR_W-1:0]   o_retire_rd_waddr,
    output logic [rv32i_pkg::XLEN-1:0]         o_retire_rd_wdata,
    output logic [rv32i_pkg::XLEN-1:0]         o_retire_pc,
    output logic [rv32i_pkg::XLEN-1:0]         o_retire_next_pc
);

    import rv32i_pkg::*;
    import wb_pkg::*;

    logic                   reg_valid;
    logic [XLEN-1:0]        reg_inst;
    logic [XLEN-1:0]        reg_pc;
    logic [XLEN-1:0]        reg_next_pc;
    logic [XLEN-1:0]        reg_alu_result;
    logic [BYTE_OFS_W-1:0]  reg_byte_offset;
    logic                   reg_unaligned_pc;
    logic                   reg_unaligned_mem;
    wb_src_e                src;                // Chosen result source
    logic                   writes_rd;
    logic [XLEN-1:0]        load_data;

    //================================================
    // MEM/WB register
    //================================================
    mem_wb_reg u_mem_wb_reg (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_valid         (i_valid),
        .i_inst          (i_inst),
        .i_pc            (i_pc),
        .i_next_pc       (i_next_pc),
        .i_alu_result    (i_alu_result),
        .i_byte_offset   (i_byte_offset),
        .i_unaligned_pc  (i_unaligned_pc),
        .i_unaligned_mem (i_unaligned_mem),
        .o_valid         (reg_valid),
        .o_inst          (reg_inst),
        .o_pc            (reg_pc),
        .o_next_pc       (reg_next_pc),
        .o_alu_result    (reg_alu_result),
        .o_byte_offset   (reg_byte_offset),
        .o_unaligned_pc  (reg_unaligned_pc),
        .o_unaligned_mem (reg_unaligned_mem)
    );

    //================================================
    // Decode, load alignment and result select
    //================================================
    wb_ctrl u_wb_ctrl (
        .i_valid         (reg_valid),
        .i_inst          (reg_inst),
        .i_unaligned_pc  (reg_unaligned_pc),
        .i_unaligned_mem (reg_unaligned_mem),
        .o_src           (src),
        .o_writes_rd     (writes_rd),
        .o_trap          (o_retire_trap),
        .o_halt          (o_retire_halt)
    );

    load_align u_load_align (
        .i_funct3        (reg_inst[FUNCT3_MSB:FUNCT3_LSB]),
        .i_byte_offset   (reg_byte_offset),
        .i_rdata         (i_dmem_rdata),        // Arrives in the WB cycle
        .o_load_data     (load_data)
    );

    wb_select u_wb_select (
        .i_src           (src),
        .i_alu_result    (reg_alu_result),
        .i_load_data     (load_data),
        .i_pc            (reg_pc),
        .i_inst          (reg_inst),
        .o_rd_data       (o_wb_rd_data)
    );

    // Register file port
    assign o_wb_rd        = reg_inst[RD_MSB:RD_LSB];
    assign o_wb_reg_write = writes_rd;

    // Retire port
    assign o_retire_valid    = reg_valid;
    assign o_retire_inst     = reg_inst;
    assign o_retire_rd_waddr = writes_rd ? o_wb_rd : '0;   // Zero when nothing is written
    assign o_retire_rd_wdata = o_wb_rd_data;
    assign o_retire_pc       = reg_pc;
    assign o_retire_next_pc  = reg_next_pc;

endmodule

`default_nettype wire

/* test/wb_stage_asserts.sv */
//================================================
// Write-back stage control assertions
//================================================

`default_nettype none
`timescale 1ns/10ps

module wb_stage_asserts (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_wb_reg_write,
    input  logic                             i_retire_valid,
    input  logic                             i_retire_trap,
    input  logic                             i_retire_halt,
    input  logic [rv32i_pkg::REG_ADDR_W-1:0] i_retire_rd_waddr
);

    a_write_needs_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_reg_write |-> i_retire_valid)
        else $error("Register write without a retiring instruction");

    a_trap_halts: assert property (@(posedge i_clk) disable iff (i_rst)
        i_retire_trap |-> i_retire_halt)
        else $error("Trap raised without halt");

    a_halt_needs_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        i_retire_halt |-> i_retire_valid)
        else $error("Halt raised on a bubble");

    a_waddr_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_wb_reg_write |-> (i_retire_rd_waddr == '0))
        else $error("Retire rd address nonzero with no write");

    // Registered reset shows one edge later
    a_reset_quiet: assert property (@(posedge i_clk)
        i_rst |=> !i_retire_valid && !i_wb_reg_write && !i_retire_trap && !i_retire_halt)
        else $error("Control outputs active after reset");

endmodule

bind wb_stage wb_stage_asserts u_wb_stage_asserts (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_wb_reg_write    (o_wb_reg_write),
    .i_retire_valid    (o_retire_valid),
    .i_retire_trap     (o_retire_trap),
    .i_retire_halt     (o_retire_halt),
    .i_retire_rd_waddr (o_retire_rd_waddr)
);

`default_nettype wire

/* test/wb_stage_tb.sv */
//================================================
// Testbench for the RV32I write-back stage
// Table of instructions applied one per cycle
//================================================

`default_nettype none
`timescale 1ns/10ps

module wb_stage_tb;

    import rv32i_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 4;
    localparam logic [XLEN-1:0] DMEM_WORD = 32'hc4b3_82f1;   // Distinct bytes, MSBs set

    typedef struct {
        string           name;
        logic            valid;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next_pc;
        logic [XLEN-1:0] alu;
        logic [1:0]      ofs;
        logic            unal_pc;
        logic            unal_mem;
        logic [XLEN-1:0] rdata;                                // Data memory word, next cycle
        logic            exp_we;
        logic [XLEN-1:0] exp_wdata;
        logic [4:0]      exp_waddr;
        logic            exp_trap;
        logic            exp_halt;
    } row_t;

    row_t rows[$];
    logic table_ready = 1'b0;                                  // Releases the watchdog

    logic            i_clk;
    logic            i_rst;
    logic            i_valid;
    logic [XLEN-1:0] i_inst;
    logic [XLEN-1:0] i_pc;
    logic [XLEN-1:0] i_next_pc;
    logic [XLEN-1:0] i_alu_result;
    logic [1:0]      i_byte_offset;
    logic            i_unaligned_pc;
    logic            i_unaligned_mem;
    logic [XLEN-1:0] i_dmem_rdata;
    logic [4:0]      o_wb_rd;
    logic [XLEN-1:0] o_wb_rd_data;
    logic            o_wb_reg_write;
    logic            o_retire_valid;
    logic [XLEN-1:0] o_retire_inst;
    logic            o_retire_trap;
    logic            o_retire_halt;
    logic [4:0]      o_retire_rd_waddr;
    logic [XLEN-1:0] o_retire_rd_wdata;
    logic [XLEN-1:0] o_retire_pc;
    logic [XLEN-1:0] o_retire_next_pc;

    wb_stage u_wb_stage (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_valid           (i_valid),
        .i_inst            (i_inst),
        .i_pc              (i_pc),
        .i_next_pc         (i_next_pc),
        .i_alu_result      (i_alu_result),
        .i_byte_offset     (i_byte_offset),
        .i_unaligned_pc    (i_unaligned_pc),
        .i_unaligned_mem   (i_unaligned_mem),
        .i_dmem_rdata      (i_dmem_rdata),
        .o_wb_rd           (o_wb_rd),
        .o_wb_rd_data      (o_wb_rd_data),
        .o_wb_reg_write    (o_wb_reg_write),
        .o_retire_valid    (o_retire_valid),
        .o_retire_inst     (o_retire_inst),
        .o_retire_trap     (o_retire_trap),
        .o_retire_halt     (o_retire_halt),
        .o_retire_rd_waddr (o_retire_rd_waddr),
        .o_retire_rd_wdata (o_retire_rd_wdata),
        .o_retire_pc       (o_retire_pc),
        .o_retire_next_pc  (o_retire_next_pc)
    );

    always #(CLK_PERIOD/2) i_clk = ~i_clk;                     // 8 ns period

    // I-type layout with rs1 = x2, also good enough for other formats
    function automatic logic [XLEN-1:0] make_inst(logic [6:0] op, logic [4:0] rd,
                                                  logic [2:0] f3, logic [11:0] imm);
        make_inst = {imm, 5'd2, f3, rd, op};
    endfunction

    task automatic compare_value(string test, logic [XLEN-1:0] expected,
                                 logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", test, expected, actual);
            $display("Errors found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic add_row(string name, logic valid, logic [XLEN-1:0] inst,
                           logic [XLEN-1:0] pc, logic [XLEN-1:0] alu, logic [1:0] ofs,
                           logic [1:0] unal, logic [XLEN-1:0] rdata, logic we,
                           logic [XLEN-1:0] wdata, logic trap, logic halt);
        row_t r;
        r.name      = name;
        r.valid     = valid;
        r.inst      = inst;
        r.pc        = pc;
        // Jumps go to the ALU target, the rest flow on
        if (inst[6:0] == JAL || inst[6:0] == JALR)
            r.next_pc = alu;
        else
            r.next_pc = pc + 32'd4;
        r.alu       = alu;
        r.ofs       = ofs;
        r.unal_pc   = unal[1];
        r.unal_mem  = unal[0];
        r.rdata     = rdata;
        r.exp_we    = we;
        r.exp_wdata = wdata;
        r.exp_waddr = we ? inst[11:7] : 5'd0;                  // rd only when written
        r.exp_trap  = trap;
        r.exp_halt  = halt;
        rows.push_back(r);
    endtask

    //================================================
    // Stimulus and expected values
    //================================================
    task automatic build_table();
        add_row("op_add", 1'b1, make_inst(OP, 5'd5, 3'd0, 12'h000), 32'h0000_0100,
                32'h1234_5678, 2'd0, 2'b00, 32'h0, 1'b1, 32'h1234_5678, 1'b0, 1'b0);
        add_row("jal", 1'b1, make_inst(JAL, 5'd1, 3'd0, 12'h040), 32'h0000_0104,
                32'hdead_beef, 2'd0, 2'b00, 32'h0, 1'b1, 32'h0000_0108, 1'b0, 1'b0);
        add_row("jalr", 1'b1, make_inst(JALR, 5'd1, 3'd0, 12'h008), 32'h0000_0108,
                32'hdead_beef, 2'd0, 2'b00, 32'h0, 1'b1, 32'h0000_010c, 1'b0, 1'b0);
        add_row("lui", 1'b1, 32'habcd_e537, 32'h0000_010c,        // lui x10, 0xabcde
                32'hdead_beef, 2'd0, 2'b00, 32'h0, 1'b1, 32'habcd_e000, 1'b0, 1'b0);
        add_row("auipc", 1'b1, 32'h1234_5597, 32'h0000_0110,      // auipc x11, 0x12345
                32'hdead_beef, 2'd0, 2'b00, 32'h0, 1'b1, 32'h1234_5110, 1'b0, 1'b0);
        // Loads at every legal offset
        add_row("lb_ofs0", 1'b1, make_inst(LOAD, 5'd8, LB, 12'h010), 32'h0000_0114,
                32'h0000_2010, 2'd0, 2'b00, DMEM_WORD, 1'b1, 32'hffff_fff1, 1'b0, 1'b0);
        add_row("lb_ofs1", 1'b1, make_inst(LOAD, 5'd8, LB, 12'h011), 32'h0000_0118,
                32'h0000_2011, 2'd1, 2'b00, DMEM_WORD, 1'b1, 32'hffff_ff82, 1'b0, 1'b0);
        add_row("lb_ofs2", 1'b1, make_inst(LOAD, 5'd8, LB, 12'h012), 32'h0000_011c,
                32'h0000_2012, 2'd2, 2'b00, DMEM_WORD, 1'b1, 32'hffff_ffb3, 1'b0, 1'b0);
        add_row("lb_ofs3", 1'b1, make_inst(LOAD, 5'd8, LB, 12'h013), 32'h0000_0120,
                32'h0000_2013, 2'd3, 2'b00, DMEM_WORD, 1'b1, 32'hffff_ffc4, 1'b0, 1'b0);
        add_row("lbu_ofs0", 1'b1, make_inst(LOAD, 5'd9, LBU, 12'h010), 32'h0000_0124,
                32'h0000_2010, 2'd0, 2'b00, DMEM_WORD, 1'b1, 32'h0000_00f1, 1'b0, 1'b0);
        add_row("lbu_ofs1", 1'b1, make_inst(LOAD, 5'd9, LBU, 12'h011), 32'h0000_0128,
                32'h0000_2011, 2'd1, 2'b00, DMEM_WORD, 1'b1, 32'h0000_0082, 1'b0, 1'b0);
        add_row("lbu_ofs2", 1'b1, make_inst(LOAD, 5'd9, LBU, 12'h012), 32'h0000_012c,
                32'h0000_2012, 2'd2, 2'b00, DMEM_WORD, 1'b1, 32'h0000_00b3, 1'b0, 1'b0);
        add_row("lbu_ofs3", 1'b1, make_inst(LOAD, 5'd9, LBU, 12'h013), 32'h0000_0130,
                32'h0000_2013, 2'd3, 2'b00, DMEM_WORD, 1'b1, 32'h0000_00c4, 1'b0, 1'b0);
        add_row("lh_ofs0", 1'b1, make_inst(LOAD, 5'd12, LH, 12'h010), 32'h0000_0134,
                32'h0000_2010, 2'd0, 2'b00, DMEM_WORD, 1'b1, 32'hffff_82f1, 1'b0, 1'b0);
        add_row("lh_ofs2", 1'b1, make_inst(LOAD, 5'd12, LH, 12'h012), 32'h0000_0138,
                32'h0000_2012, 2'd2, 2'b00, DMEM_WORD, 1'b1, 32'hffff_c4b3, 1'b0, 1'b0);
        add_row("lhu_ofs0", 1'b1, make_inst(LOAD, 5'd13, LHU, 12'h010), 32'h0000_013c,
                32'h0000_2010, 2'd0, 2'b00, DMEM_WORD, 1'b1, 32'h0000_82f1, 1'b0, 1'b0);
        add_row("lhu_ofs2", 1'b1, make_inst(LOAD, 5'd13, LHU, 12'h012), 32'h0000_0140,
                32'h0000_2012, 2'd2, 2'b00, DMEM_WORD, 1'b1, 32'h0000_c4b3, 1'b0, 1'b0);
        add_row("lw_ofs0", 1'b1, make_inst(LOAD, 5'd14, LW, 12'h010), 32'h0000_0144,
                32'h0000_2010, 2'd0, 2'b00, DMEM_WORD, 1'b1, DMEM_WORD, 1'b0, 1'b0);
        // No destination register
        add_row("store", 1'b1, make_inst(STORE, 5'd5, 3'd2, 12'h000), 32'h0000_0148,
                32'h0000_3000, 2'd0, 2'b00, 32'h0, 1'b0, 32'h0000_3000, 1'b0, 1'b0);
        add_row("branch", 1'b1, make_inst(BRANCH, 5'd3, 3'd1, 12'h000), 32'h0000_014c,
                32'h0000_0001, 2'd0, 2'b00, 32'h0, 1'b0, 32'h0000_0001, 1'b0, 1'b0);
        add_row("ecall", 1'b1, 32'h0000_0073, 32'h0000_0150,
                32'h0000_0000, 2'd0, 2'b00, 32'h0, 1'b0, 32'h0000_0000, 1'b0, 1'b0);
        // Halt and trap cases
        add_row("ebreak", 1'b1, 32'h0010_0073, 32'h0000_0154,
                32'h0000_0000, 2'd0, 2'b00, 32'h0, 1'b0, 32'h0000_0000, 1'b0, 1'b1);
        add_row("bad_opcode", 1'b1, make_inst(7'h7f, 5'd4, 3'd0, 12'h000), 32'h0000_0158,
                32'h0000_0055, 2'd0, 2'b00, 32'h0, 1'b0, 32'h0000_0055, 1'b1, 1'b1);
        add_row("unaligned_pc", 1'b1, make_inst(JAL, 5'd1, 3'd0, 12'h040), 32'h0000_015e,
                32'h0000_0000, 2'd0, 2'b10, 32'h0, 1'b1, 32'h0000_0162, 1'b1, 1'b1);
        add_row("unaligned_mem", 1'b1, make_inst(LOAD, 5'd8, LW, 12'h012), 32'h0000_0164,
                32'h0000_2012, 2'd2, 2'b01, DMEM_WORD, 1'b1, DMEM_WORD, 1'b1, 1'b1);
        // Bubbles, then a valid row straight after
        add_row("bubble", 1'b0, make_inst(OP, 5'd5, 3'd0, 12'h000), 32'h0000_0168,
                32'h0000_0077, 2'd0, 2'b00, 32'h0, 1'b0, 32'h0000_0077, 1'b0, 1'b0);
        add_row("bubble_bad", 1'b0, make_inst(7'h7f, 5'd4, 3'd0, 12'h000), 32'h0000_016a,
                32'h0000_0088, 2'd0, 2'b11, 32'h0, 1'b0, 32'h0000_0088, 1'b0, 1'b0);
        add_row("op_after_bubble", 1'b1, make_inst(OP, 5'd6, 3'd0, 12'h000), 32'h0000_016c,
                32'hcafe_f00d, 2'd0, 2'b00, 32'h0, 1'b1, 32'hcafe_f00d, 1'b0, 1'b0);
    endtask

    task automatic drive_row(row_t r);
        i_valid         <= r.valid;
        i_inst          <= r.inst;
        i_pc            <= r.pc;
        i_next_pc       <= r.next_pc;
        i_alu_result    <= r.alu;
        i_byte_offset   <= r.ofs;
        i_unaligned_pc  <= r.unal_pc;
        i_unaligned_mem <= r.unal_mem;
    endtask

    task automatic check_row(row_t r);
        compare_value({r.name, " retire_valid"}, r.valid, o_retire_valid);
        compare_value({r.name, " retire_inst"}, r.inst, o_retire_inst);
        compare_value({r.name, " retire_pc"}, r.pc, o_retire_pc);
        compare_value({r.name, " retire_next_pc"}, r.next_pc, o_retire_next_pc);
        compare_value({r.name, " wb_rd"}, r.inst[11:7], o_wb_rd);    // rd field
        compare_value({r.name, " reg_write"}, r.exp_we, o_wb_reg_write);
        compare_value({r.name, " wb_rd_data"}, r.exp_wdata, o_wb_rd_data);
        compare_value({r.name, " retire_rd_wdata"}, r.exp_wdata, o_retire_rd_wdata);
        compare_value({r.name, " retire_rd_waddr"}, r.exp_waddr, o_retire_rd_waddr);
        compare_value({r.name, " trap"}, r.exp_trap, o_retire_trap);
        compare_value({r.name, " halt"}, r.exp_halt, o_retire_halt);
    endtask

    //================================================
    // Main sequence
    //================================================
    initial begin
        i_clk           = 1'b0;
        i_rst           = 1'b1;
        i_valid         = 1'b1;                                // Busy inputs, masked by reset
        i_inst          = 32'hffff_ffff;                       // Illegal opcode
        i_pc            = '0;
        i_next_pc       = '0;
        i_alu_result    = '0;
        i_byte_offset   = '0;
        i_unaligned_pc  = 1'b1;
        i_unaligned_mem = 1'b1;
        i_dmem_rdata    = '0;
        build_table();
        table_ready = 1'b1;
        for (int k = 0; k < RST_CYCLES; k++) begin
            @(posedge i_clk);
            if (k == RST_CYCLES - 1) begin
                i_rst           <= 1'b0;                       // Fourth edge is the last
                i_valid         <= 1'b0;
                i_inst          <= NOP_INST;
                i_unaligned_pc  <= 1'b0;
                i_unaligned_mem <= 1'b0;
            end
            @(negedge i_clk);
            compare_value("reset retire_valid", 1'b0, o_retire_valid);
            compare_value("reset reg_write", 1'b0, o_wb_reg_write);
            compare_value("reset trap", 1'b0, o_retire_trap);
            compare_value("reset halt", 1'b0, o_retire_halt);
            compare_value("reset retire_inst", NOP_INST, o_retire_inst);
        end
        // Row j enters while row j-1 retires
        for (int j = 0; j <= rows.size(); j++) begin
            @(posedge i_clk);
            if (j < rows.size())
                drive_row(rows[j]);
            else
                i_valid <= 1'b0;                               // Drain
            if (j > 0)
                i_dmem_rdata <= rows[j-1].rdata;               // Read word in WB cycle
            @(negedge i_clk);
            if (j > 0)
                check_row(rows[j-1]);
        end
        $display("No errors");
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        #((rows.size() + RST_CYCLES + 10) * CLK_PERIOD);
        $display("Errors found");
        $fatal(1, "Timeout: the table did not finish in the expected number of cycles");
    end

endmodule

`default_nettype wire

/* project.f */
logic/rv32i_pkg.sv
logic/wb_pkg.sv
logic/mem_wb_reg.sv
logic/wb_ctrl.sv
logic/load_align.sv
logic/wb_select.sv
logic/wb_stage.sv
test/wb_stage_asserts.sv
test/wb_stage_tb.sv
